/* Bender.yml */
package:
  name: cpu_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/isa_pkg.sv
      - hdl/ctrl_pkg.sv
      - hdl/word_mem.sv
      - hdl/reg_file.sv
      - hdl/alu.sv
      - hdl/cpu_control.sv
      - hdl/cpu_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - sim/cpu_checker.sv
      - sim/cpu_tb.sv

/* hdl/alu.sv */
module alu import isa_pkg::*, ctrl_pkg::*; (
  input  alu_op_e op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result,
  output logic    zero
);

  always_comb begin
    case (op)
      ALU_ADD: begin
        result = a + b;
      end
      ALU_SUB: begin
        result = a - b;
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_OR: begin
        result = a | b;
      end
      ALU_XOR: begin
        result = a ^ b;
      end
      ALU_SLT: begin
        result = word_t'($signed(a) < $signed(b)); // Signed compare, 1 or 0.
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // With op SUB this is the equality test of BEQ.
  assign zero = (result == '0);

endmodule

/* hdl/cpu_control.sv */
`include "cpu_defines.svh"

module cpu_control import isa_pkg::*, ctrl_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  output logic               busy,
  output logic               halted,
  input  logic               im_load_we,
  input  logic [`ADDR_W-1:0] im_load_addr,
  input  instr_t             im_load_data,
  input  logic               dm_host_we,
  input  logic               dm_host_re,
  input  logic [`ADDR_W-1:0] dm_host_addr,
  input  word_t              dm_host_wdata,
  output logic               im_enable,
  output logic               im_read,
  output logic               im_write,
  output logic [`ADDR_W-1:0] im_address,
  output instr_t             im_wdata,
  input  instr_t             instruction,
  output logic               dm_enable,
  output logic               dm_read,
  output logic               dm_write,
  output logic [`ADDR_W-1:0] dm_address,
  output word_t              dm_wdata,
  input  word_t              dm_rdata,
  output logic [`REG_W-1:0]  rs_idx,
  output logic [`REG_W-1:0]  rt_idx,
  output logic [`REG_W-1:0]  rd_idx,
  output logic               reg_we,
  output word_t              rd_data,
  input  word_t              rs_data,
  input  word_t              rt_data,
  output alu_op_e            alu_op,
  output word_t              alu_b,
  input  word_t              alu_result,
  input  logic               alu_zero
);

  cpu_state_e state;
  word_t      pc;
  instr_t     ir;
  word_t      alu_out;
  word_t      imm_ext;
  logic       use_imm;
  logic       exec_op;

  assign busy    = !(state inside {IDLE, HALTED});
  assign halted  = (state == HALTED);
  assign imm_ext = word_t'($signed(ir.imm));

  always_comb begin
    alu_op  = ALU_ADD;
    use_imm = 1'b0;
    case (ir.opcode)
      OP_SUB, OP_BEQ: alu_op = ALU_SUB;
      OP_AND: alu_op = ALU_AND;
      OP_OR: alu_op = ALU_OR;
      OP_XOR: alu_op = ALU_XOR;
      OP_SLT: alu_op = ALU_SLT;
      OP_ADDI, OP_LW, OP_SW: use_imm = 1'b1;
      default: ;
    endcase
  end

  // HALT and unknown opcodes both stop the core after decode.
  always_comb begin
    case (instruction.opcode)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
      OP_ADDI, OP_LW, OP_SW, OP_BEQ: exec_op = 1'b1;
      default: exec_op = 1'b0;
    endcase
  end

  assign rs_idx  = ir.rs;
  assign rt_idx  = ir.rt;
  assign rd_idx  = ir.rd;
  assign reg_we  = (state == WRITEBACK);
  assign rd_data = (ir.opcode == OP_LW) ? dm_rdata : alu_out;
  assign alu_b   = use_imm ? imm_ext : rt_data;

  always_comb begin
    im_enable  = 1'b0;
    im_read    = 1'b0;
    im_write   = 1'b0;
    im_address = pc[`ADDR_W-1:0];
    im_wdata   = im_load_data;
    dm_enable  = 1'b0;
    dm_read    = 1'b0;
    dm_write   = 1'b0;
    dm_address = alu_out[`ADDR_W-1:0];
    dm_wdata   = rt_data; // Store data of SW.
    if (!busy) begin // The host owns both memories.
      im_enable  = im_load_we;
      im_write   = im_load_we;
      im_address = im_load_addr;
      dm_enable  = dm_host_we || dm_host_re;
      dm_read    = dm_host_re;
      dm_write   = dm_host_we;
      dm_address = dm_host_addr;
      dm_wdata   = dm_host_wdata;
    end else if (state == FETCH) begin
      im_enable = 1'b1;
      im_read   = 1'b1;
    end else if (state == MEMORY) begin
      dm_enable = 1'b1;
      dm_read   = (ir.opcode == OP_LW);
      dm_write  = (ir.opcode == OP_SW);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      pc    <= word_t'(`PC_START);
      ir    <= '0;
    end else begin
      case (state)
        IDLE, HALTED: begin
          if (start) begin
            state <= FETCH;
            pc    <= word_t'(`PC_START);
          end
        end
        FETCH: state <= DECODE;
        DECODE: begin
          ir    <= instruction;
          pc    <= pc + 1'b1;
          state <= exec_op ? EXECUTE : HALTED;
        end
        EXECUTE: begin
          if (ir.opcode == OP_BEQ) begin
            state <= FETCH;
            if (alu_zero) begin
              pc <= pc + imm_ext; // The PC already points past the branch.
            end
          end else if (ir.opcode inside {OP_LW, OP_SW}) begin
            state <= MEMORY;
          end else begin
            state <= WRITEBACK;
          end
        end
        MEMORY: state <= (ir.opcode == OP_LW) ? WRITEBACK : FETCH;
        WRITEBACK: state <= FETCH;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == EXECUTE) begin
      alu_out <= alu_result;
    end
  end

  a_pc_in_range: assert property (
    @(posedge clk) disable iff (rst) (state == FETCH) |-> (pc < `IM_DEPTH)
  );

  a_no_host_when_busy: assert property (
    @(posedge clk) disable iff (rst) busy |-> !(im_load_we || dm_host_we || dm_host_re)
  );

endmodule

/* hdl/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data and instruction width.
`define WORD_W 32

// Both memories hold 1024 words.
`define IM_DEPTH 1024
`define DM_DEPTH 1024

// Word address width of either memory.
`define ADDR_W 10

`define REG_CNT 16
`define REG_W 4

// First instruction of every program, as a word address.
`define PC_START 'h80

`endif

/* hdl/cpu_top.sv */
`include "cpu_defines.svh"

module cpu_top import isa_pkg::*, ctrl_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  output logic               busy,
  output logic               halted,
  input  logic               im_load_we,
  input  logic [`ADDR_W-1:0] im_load_addr,
  input  instr_t             im_load_data,
  input  logic               dm_host_we,
  input  logic               dm_host_re,
  input  logic [`ADDR_W-1:0] dm_host_addr,
  input  word_t              dm_host_wdata,
  output word_t              dm_host_rdata
);

  logic               im_enable;
  logic               im_read;
  logic               im_write;
  logic [`ADDR_W-1:0] im_address;
  instr_t             im_wdata;
  instr_t             instruction;
  logic               dm_enable;
  logic               dm_read;
  logic               dm_write;
  logic [`ADDR_W-1:0] dm_address;
  word_t              dm_wdata;
  logic [`REG_W-1:0]  rs_idx;
  logic [`REG_W-1:0]  rt_idx;
  logic [`REG_W-1:0]  rd_idx;
  logic               reg_we;
  word_t              rd_data;
  word_t              rs_data;
  word_t              rt_data;
  alu_op_e            alu_op;
  word_t              alu_b;
  word_t              alu_result;
  logic               alu_zero;

  cpu_control ctrl_i (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .busy          (busy),
    .halted        (halted),
    .im_load_we    (im_load_we),
    .im_load_addr  (im_load_addr),
    .im_load_data  (im_load_data),
    .dm_host_we    (dm_host_we),
    .dm_host_re    (dm_host_re),
    .dm_host_addr  (dm_host_addr),
    .dm_host_wdata (dm_host_wdata),
    .im_enable     (im_enable),
    .im_read       (im_read),
    .im_write      (im_write),
    .im_address    (im_address),
    .im_wdata      (im_wdata),
    .instruction   (instruction),
    .dm_enable     (dm_enable),
    .dm_read       (dm_read),
    .dm_write      (dm_write),
    .dm_address    (dm_address),
    .dm_wdata      (dm_wdata),
    .dm_rdata      (dm_host_rdata),
    .rs_idx        (rs_idx),
    .rt_idx        (rt_idx),
    .rd_idx        (rd_idx),
    .reg_we        (reg_we),
    .rd_data       (rd_data),
    .rs_data       (rs_data),
    .rt_data       (rt_data),
    .alu_op        (alu_op),
    .alu_b         (alu_b),
    .alu_result    (alu_result),
    .alu_zero      (alu_zero)
  );

  word_mem #(.data_t(instr_t), .depth(`IM_DEPTH)) im_i (
    .clk     (clk),
    .rst     (rst),
    .enable  (im_enable),
    .read    (im_read),
    .write   (im_write),
    .address (im_address),
    .wdata   (im_wdata),
    .rdata   (instruction)
  );

  // Read data serves the core and the host readback alike.
  word_mem #(.data_t(word_t), .depth(`DM_DEPTH)) dm_i (
    .clk     (clk),
    .rst     (rst),
    .enable  (dm_enable),
    .read    (dm_read),
    .write   (dm_write),
    .address (dm_address),
    .wdata   (dm_wdata),
    .rdata   (dm_host_rdata)
  );

  reg_file rf_i (
    .clk     (clk),
    .rst     (rst),
    .rs_idx  (rs_idx),
    .rt_idx  (rt_idx),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .we      (reg_we),
    .rd_idx  (rd_idx),
    .rd_data (rd_data)
  );

  alu alu_i (
    .op     (alu_op),
    .a      (rs_data),
    .b      (alu_b),
    .result (alu_result),
    .zero   (alu_zero)
  );

endmodule

/* hdl/ctrl_pkg.sv */
package ctrl_pkg;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    DECODE,
    EXECUTE,
    MEMORY,
    WRITEBACK,
    HALTED
  } cpu_state_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

endpackage

/* hdl/isa_pkg.sv */
`include "cpu_defines.svh"

package isa_pkg;

  typedef logic [`WORD_W-1:0] word_t;

  // Encodings of the eleven instructions.
  typedef enum logic [5:0] {
    OP_ADD  = 6'h01,
    OP_SUB  = 6'h02,
    OP_AND  = 6'h03,
    OP_OR   = 6'h04,
    OP_XOR  = 6'h05,
    OP_SLT  = 6'h06,
    OP_ADDI = 6'h08,
    OP_LW   = 6'h10,
    OP_SW   = 6'h11,
    OP_BEQ  = 6'h18,
    OP_HALT = 6'h3f
  } opcode_e;

  // All instructions share one format.
  // ALU ops use rd = rs op rt, ADDI and LW write rd from rs + imm.
  // SW stores rt at rs + imm, BEQ compares rs with rt.
  typedef struct packed {
    opcode_e            opcode;
    logic [3:0]         rd;
    logic [3:0]         rs;
    logic [3:0]         rt;
    logic signed [13:0] imm;
  } instr_t;

endpackage

/* hdl/reg_file.sv */
`include "cpu_defines.svh"

module reg_file import isa_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [`REG_W-1:0] rs_idx,
  input  logic [`REG_W-1:0] rt_idx,
  output word_t             rs_data,
  output word_t             rt_data,
  input  logic              we,
  input  logic [`REG_W-1:0] rd_idx,
  input  word_t             rd_data
);

  word_t regs [`REG_CNT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `REG_CNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_idx != '0) begin // Register zero stays zero.
      regs[rd_idx] <= rd_data;
    end
  end

  assign rs_data = regs[rs_idx];
  assign rt_data = regs[rt_idx];

endmodule

/* hdl/word_mem.sv */
`include "cpu_defines.svh"

module word_mem #(
  parameter type data_t = logic [`WORD_W-1:0],
  parameter int  depth  = `DM_DEPTH
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               enable,
  input  logic               read,
  input  logic               write,
  input  logic [`ADDR_W-1:0] address,
  input  data_t              wdata,
  output data_t              rdata
);

  data_t mem [depth];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] <= '0;
      end
      rdata <= '0;
    end else if (enable) begin
      if (read) begin
        rdata <= mem[address]; // Data is seen one cycle later.
      end else if (write) begin
        mem[address] <= wdata;
      end
    end
  end

  a_no_read_write: assert property (
    @(posedge clk) disable iff (rst) enable |-> !(read && write)
  );

endmodule

/* sim.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/word_mem.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/cpu_control.sv
hdl/cpu_top.sv
sim/cpu_checker.sv
sim/cpu_tb.sv

/* sim/cpu_checker.sv */
`include "cpu_defines.svh"

module cpu_checker import isa_pkg::*; (
  input logic               clk,
  input logic               rst,
  input logic               busy,
  input logic               halted,
  input logic               im_load_we,
  input logic [`ADDR_W-1:0] im_load_addr,
  input instr_t             im_load_data,
  input logic               dm_host_we,
  input logic               dm_host_re,
  input logic [`ADDR_W-1:0] dm_host_addr,
  input word_t              dm_host_wdata,
  input word_t              dm_host_rdata
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_INSTR = 200;

  instr_t             model_im [`IM_DEPTH];
  word_t              model_dm [`DM_DEPTH];
  word_t              model_regs [`REG_CNT];
  logic               halted_q;
  logic               read_pending;
  logic [`ADDR_W-1:0] read_addr;
  word_t              read_expected;
  string              test_name = "none";
  int                 test_errors = 0;
  int                 tests_passed = 0;
  int                 tests_failed = 0;

  function automatic void clear_model();
    for (int i = 0; i < `IM_DEPTH; i++) begin
      model_im[i] = '0;
      model_dm[i] = '0;
    end
    for (int i = 0; i < `REG_CNT; i++) begin
      model_regs[i] = '0;
    end
  endfunction

  // Executes the program held in the model memories, following the ISA.
  // Returns 1 when HALT or an unknown opcode is reached.
  function automatic bit run_reference();
    int     pc;
    int     imm;
    instr_t ins;
    word_t  a;
    word_t  b;
    word_t  ea;
    word_t  res;
    bit     wb;
    pc = `PC_START;
    for (int n = 0; n < MAX_INSTR; n++) begin
      if (pc < 0 || pc >= `IM_DEPTH) begin
        return 1'b0;
      end
      ins = model_im[pc];
      a   = model_regs[ins.rs];
      b   = model_regs[ins.rt];
      imm = $signed(ins.imm);
      ea  = a + word_t'(imm); // Also the ADDI sum.
      res = '0;
      wb  = 1'b1;
      pc  = pc + 1;
      case (ins.opcode)
        OP_ADD:  res = a + b;
        OP_SUB:  res = a - b;
        OP_AND:  res = a & b;
        OP_OR:   res = a | b;
        OP_XOR:  res = a ^ b;
        OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        OP_ADDI: res = ea;
        OP_LW:   res = model_dm[ea[`ADDR_W-1:0]];
        OP_SW: begin
          model_dm[ea[`ADDR_W-1:0]] = b;
          wb = 1'b0;
        end
        OP_BEQ: begin
          if (a == b) begin
            pc = pc + imm; // Relative to the next instruction.
          end
          wb = 1'b0;
        end
        default: return 1'b1;
      endcase
      if (wb && ins.rd != '0) begin
        model_regs[ins.rd] = res;
      end
    end
    return 1'b0;
  endfunction

  task automatic mismatch(input string what, input word_t expected, input word_t actual);
    $display("MISMATCH %s %s expected 0x%08h actual 0x%08h", test_name, what, expected, actual);
    test_errors++;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR %s: %s", test_name, msg);
    test_errors++;
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      $display("PASS %s", test_name);
      tests_passed++;
    end else begin
      $display("FAIL %s with %0d errors", test_name, test_errors);
      tests_failed++;
    end
  endtask

  task automatic check_status(input logic exp_busy, input logic exp_halted);
    @(posedge clk);
    if (busy !== exp_busy) begin
      mismatch("busy", word_t'(exp_busy), word_t'(busy));
    end
    if (halted !== exp_halted) begin
      mismatch("halted", word_t'(exp_halted), word_t'(halted));
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      clear_model();
      halted_q     = 1'b0;
      read_pending = 1'b0;
    end else begin
      if (read_pending && dm_host_rdata !== read_expected) begin
        mismatch($sformatf("dm[0x%03h]", read_addr), read_expected, dm_host_rdata);
      end
      read_pending = 1'b0;
      if (!busy && dm_host_re) begin // Read wins over a write in the same cycle.
        read_pending  = 1'b1;
        read_addr     = dm_host_addr;
        read_expected = model_dm[dm_host_addr];
      end else if (!busy && dm_host_we) begin
        model_dm[dm_host_addr] = dm_host_wdata;
      end
      if (!busy && im_load_we) begin
        model_im[im_load_addr] = im_load_data;
      end
      if (halted && !halted_q && !run_reference()) begin
        report_error("reference model did not reach HALT within 200 instructions");
      end
      if (halted && busy) begin
        report_error("busy is high while halted");
      end
      halted_q = halted;
    end
  end

endmodule

/* sim/cpu_tb.sv */
`include "cpu_defines.svh"

module cpu_tb import isa_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  typedef logic [`ADDR_W-1:0] addr_t;

  localparam int RANDOM_RUNS     = 20;
  localparam int TEST_CNT        = 5 + RANDOM_RUNS;
  localparam int LOAD_CYCLES     = 128;
  localparam int RUN_CYCLES      = 200 * 5;
  localparam int READBACK_CYCLES = 32;
  localparam int WATCHDOG_NS     = TEST_CNT * (LOAD_CYCLES + RUN_CYCLES + READBACK_CYCLES) * 4;

  logic   clk;
  logic   rst;
  logic   start;
  logic   busy;
  logic   halted;
  logic   im_load_we;
  addr_t  im_load_addr;
  instr_t im_load_data;
  logic   dm_host_we;
  logic   dm_host_re;
  addr_t  dm_host_addr;
  word_t  dm_host_wdata;
  word_t  dm_host_rdata;
  instr_t prog [$];

  cpu_top dut_i (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .busy          (busy),
    .halted        (halted),
    .im_load_we    (im_load_we),
    .im_load_addr  (im_load_addr),
    .im_load_data  (im_load_data),
    .dm_host_we    (dm_host_we),
    .dm_host_re    (dm_host_re),
    .dm_host_addr  (dm_host_addr),
    .dm_host_wdata (dm_host_wdata),
    .dm_host_rdata (dm_host_rdata)
  );

  cpu_checker chk_i (
    .clk           (clk),
    .rst           (rst),
    .busy          (busy),
    .halted        (halted),
    .im_load_we    (im_load_we),
    .im_load_addr  (im_load_addr),
    .im_load_data  (im_load_data),
    .dm_host_we    (dm_host_we),
    .dm_host_re    (dm_host_re),
    .dm_host_addr  (dm_host_addr),
    .dm_host_wdata (dm_host_wdata),
    .dm_host_rdata (dm_host_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic instr_t encode(input opcode_e op, input int rd, input int rs,
                                    input int rt, input int imm);
    instr_t ins;
    ins.opcode = op;
    ins.rd     = rd[3:0];
    ins.rs     = rs[3:0];
    ins.rt     = rt[3:0];
    ins.imm    = imm[13:0];
    return ins;
  endfunction

  function automatic opcode_e random_op();
    case ($urandom_range(6, 0))
      0: return OP_ADD;
      1: return OP_SUB;
      2: return OP_AND;
      3: return OP_OR;
      4: return OP_XOR;
      5: return OP_SLT;
      default: return OP_ADDI;
    endcase
  endfunction

  task automatic emit(input opcode_e op, input int rd, input int rs, input int rt, input int imm);
    prog.push_back(encode(op, rd, rs, rt, imm));
  endtask

  // SW of registers first..last to consecutive words from base, addressed through r0.
  task automatic store_regs(input int first, input int last, input int base);
    for (int r = first; r <= last; r++) begin
      emit(OP_SW, 0, 0, r, base + r - first);
    end
  endtask

  task automatic load_program();
    foreach (prog[i]) begin
      @(posedge clk);
      im_load_we   <= 1'b1;
      im_load_addr <= addr_t'(`PC_START + i);
      im_load_data <= prog[i];
    end
    @(posedge clk);
    im_load_we <= 1'b0;
  endtask

  task automatic preload_word(input int addr, input word_t data);
    @(posedge clk);
    dm_host_we    <= 1'b1;
    dm_host_addr  <= addr_t'(addr);
    dm_host_wdata <= data;
    @(posedge clk);
    dm_host_we <= 1'b0;
  endtask

  task automatic read_back(input int base, input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge clk);
      dm_host_re   <= 1'b1;
      dm_host_addr <= addr_t'(base + i);
    end
    @(posedge clk);
    dm_host_re <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic run_program();
    int cycles;
    cycles = 0;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!halted && cycles < RUN_CYCLES + 16);
    if (!halted) begin
      chk_i.report_error("core did not reach halted in time");
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns", WATCHDOG_NS);
    $display("tests failed");
    $finish;
  end

  initial begin
    int rd;
    int rs;
    int rt;
    int imm;
    void'($urandom(32'h484));
    rst           = 1'b1;
    start         = 1'b0;
    im_load_we    = 1'b0;
    im_load_addr  = '0;
    im_load_data  = '0;
    dm_host_we    = 1'b0;
    dm_host_re    = 1'b0;
    dm_host_addr  = '0;
    dm_host_wdata = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    chk_i.start_test("alu_ops");
    prog.delete();
    emit(OP_ADDI, 1, 0, 0, 1234);
    emit(OP_ADDI, 2, 0, 0, 567);
    emit(OP_ADD, 3, 1, 2, 0);
    emit(OP_SUB, 4, 1, 2, 0);
    emit(OP_AND, 5, 1, 2, 0);
    emit(OP_OR, 6, 1, 2, 0);
    emit(OP_XOR, 7, 1, 2, 0);
    emit(OP_ADDI, 8, 1, 0, 100);
    store_regs(1, 8, 'h10);
    emit(OP_HALT, 0, 0, 0, 0);
    load_program();
    run_program();
    read_back('h10, 16);
    chk_i.finish_test();

    chk_i.start_test("signed_ops");
    prog.delete();
    emit(OP_ADDI, 1, 0, 0, -5);
    emit(OP_ADDI, 2, 0, 0, 3);
    emit(OP_SLT, 3, 1, 2, 0);
    emit(OP_SLT, 4, 2, 1, 0);
    emit(OP_ADDI, 5, 0, 0, -8192); // Most negative immediate.
    emit(OP_SLT, 6, 5, 1, 0);
    emit(OP_ADDI, 0, 0, 0, 77);
    emit(OP_ADD, 0, 1, 2, 0);
    emit(OP_ADD, 7, 0, 0, 0);
    emit(OP_SUB, 8, 2, 1, 0);
    store_regs(0, 8, 'h30);
    emit(OP_HALT, 0, 0, 0, 0);
    load_program();
    run_program();
    read_back('h30, 9);
    chk_i.finish_test();

    chk_i.start_test("memory_traffic");
    for (int i = 0; i < 8; i++) begin
      preload_word('h40 + i, 32'ha5a5_0000 + 32'h1111 * i);
    end
    prog.delete();
    emit(OP_LW, 1, 0, 0, 'h40);
    emit(OP_LW, 2, 0, 0, 'h41);
    emit(OP_ADD, 3, 1, 2, 0);
    emit(OP_SW, 0, 0, 3, 'h50);
    emit(OP_ADDI, 4, 0, 0, 'h42);
    emit(OP_LW, 5, 4, 0, 1);
    emit(OP_XOR, 6, 5, 1, 0);
    emit(OP_SW, 0, 4, 6, 'h10);
    emit(OP_SW, 0, 0, 5, 'h51);
    emit(OP_HALT, 0, 0, 0, 0);
    load_program();
    run_program();
    read_back('h40, 24);
    chk_i.finish_test();

    chk_i.start_test("control_flow");
    prog.delete();
    emit(OP_ADDI, 1, 0, 0, 10);
    emit(OP_ADDI, 2, 0, 0, 0);
    emit(OP_BEQ, 0, 1, 0, 3); // Leaves the loop once the count is zero.
    emit(OP_ADD, 2, 2, 1, 0);
    emit(OP_ADDI, 1, 1, 0, -1);
    emit(OP_BEQ, 0, 0, 0, -4);
    emit(OP_SW, 0, 0, 2, 'h60);
    emit(OP_BEQ, 0, 1, 2, 1); // Not taken.
    emit(OP_ADDI, 3, 0, 0, 7);
    emit(OP_SW, 0, 0, 3, 'h61);
    emit(OP_HALT, 0, 0, 0, 0);
    load_program();
    run_program();
    chk_i.check_status(1'b0, 1'b1);
    read_back('h60, 2);
    chk_i.finish_test();

    for (int run = 0; run < RANDOM_RUNS; run++) begin
      chk_i.start_test($sformatf("random_%0d", run));
      prog.delete();
      for (int n = 0; n < 24; n++) begin
        rd  = $urandom_range(15, 0);
        rs  = $urandom_range(15, 0);
        rt  = $urandom_range(15, 0);
        imm = int'($urandom_range(16383, 0)) - 8192;
        emit(random_op(), rd, rs, rt, imm);
      end
      store_regs(0, 15, 'h100 + 16 * run);
      emit(OP_HALT, 0, 0, 0, 0);
      load_program();
      run_program();
      read_back('h100 + 16 * run, 16);
      chk_i.finish_test();
    end

    chk_i.start_test("reset");
    @(posedge clk);
    rst <= 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    chk_i.check_status(1'b0, 1'b0);
    read_back('h40, 8);
    read_back('h100, 16);
    chk_i.finish_test();

    $display("%0d tests run, %0d passed, %0d failed", chk_i.tests_passed + chk_i.tests_failed,
             chk_i.tests_passed, chk_i.tests_failed);
    if (chk_i.tests_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
